// File: run_sim.sh
#!/bin/bash
# build the soc_core testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f soc_core.f --top-module tb_soc_core \
	-Mdir obj_dir -o tb_soc_core || exit 1
sim_out="$(./obj_dir/tb_soc_core)"
echo "$sim_out"
grep -qx "STATUS: PASS" <<< "$sim_out" && exit 0 || exit 1

// File: soc_core.f
verilog/soc_pkg.sv
verilog/periph_bus_if.sv
verilog/bus_decoder.sv
verilog/sram_block.sv
verilog/simple_uart.sv
verilog/ctrl_regs.sv
verilog/soc_core.sv
tests/tb_soc_core.sv

// File: tests/tb_soc_core.sv
// testbench for the soc peripheral core.
// plays the cpu bus master with seeded random traffic and checks ram,
// uart, control registers and unmapped space against a model.

`timescale 1ns/10ps

module tb_soc_core import soc_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int SAMPLE_DELAY = CLK_PERIOD / 4;   // settled, before the rising edge.
	localparam int WAIT_LIMIT   = 2000;             // cycles per bus access.
	localparam int POLL_LIMIT   = 500;              // reads per loopback byte.

	localparam logic [BUS_W-1:0] UART_DATA = {REGION_UART, 28'h0};
	localparam logic [BUS_W-1:0] UART_DIV  = {REGION_UART, 28'h4};
	localparam logic [BUS_W-1:0] CTRL_LED  = {REGION_CTRL, 28'h0};

	logic               clk48m;
	logic               resetn;
	logic               mem_valid;
	logic [BUS_W-1:0]   mem_addr;
	logic [BUS_W-1:0]   mem_wdata;
	logic [STRB_W-1:0]  mem_wstrb;
	logic               mem_ready;
	logic [BUS_W-1:0]   mem_rdata;
	logic [LED_W-1:0]   led;
	logic               uart_tx;
	logic               uart_rx;

	logic [BUS_W-1:0]   ram_model [RAM_WORDS];
	int                 errors;
	int                 checks;
	int                 err_mark;
	int                 chk_mark;
	int                 tests_run;
	int                 tests_failed;

	assign uart_rx = uart_tx;   // loopback.

	soc_core uut (.*);

	initial begin
		clk48m = 1'b0;
		forever #(CLK_PERIOD / 2) clk48m = ~clk48m;
	end

	// ####################################################################
	// model helpers and checks
	// ####################################################################
	function automatic logic [BUS_W-1:0] merge_bytes(input logic [BUS_W-1:0] old_word,
			input logic [BUS_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [BUS_W-1:0] merged;
		merged = old_word;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i])
				merged[8*i +: 8] = new_word[8*i +: 8];
		end
		return merged;
	endfunction

	function automatic logic [BUS_W-1:0] fill_word(input logic [RAM_AW-1:0] idx);
		return {~idx, idx ^ 8'h5a, idx + 8'h33, idx};
	endfunction

	task automatic check_word(input string name, input logic [BUS_W-1:0] expected,
			input logic [BUS_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_led(input string name, input logic [LED_W-1:0] expected,
			input logic [LED_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_cycles(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		int n_err;
		int n_chk;
		n_err = errors - err_mark;
		n_chk = checks - chk_mark;
		tests_run++;
		if (n_err == 0) begin
			$display("test %-14s ok, %0d checks", name, n_chk);
		end else begin
			tests_failed++;
			$display("test %-14s FAILED, %0d errors in %0d checks", name, n_err, n_chk);
		end
		err_mark = errors;
		chk_mark = checks;
	endtask

	// ####################################################################
	// bus master
	// ####################################################################
	// waits counts the cycles between mem_valid rising and mem_ready.
	task automatic bus_access(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
			input logic [STRB_W-1:0] wstrb, output logic [BUS_W-1:0] rdata, output int waits);
		bit done;
		done  = 1'b0;
		waits = 0;
		rdata = '0;
		@(negedge clk48m);
		mem_valid = 1'b1;
		mem_addr  = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		while (!done && waits <= WAIT_LIMIT) begin
			#(SAMPLE_DELAY);
			if (mem_ready === 1'b1) begin
				done  = 1'b1;
				rdata = mem_rdata;
			end else begin
				waits++;
				@(negedge clk48m);
			end
		end
		if (done) begin
			@(negedge clk48m);
		end else begin
			errors++;
			$display("bus access to %h got no mem_ready within %0d cycles", addr, WAIT_LIMIT);
		end
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	task automatic bus_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
			input logic [STRB_W-1:0] wstrb, output int waits);
		logic [BUS_W-1:0] rdata_drop;
		bus_access(addr, wdata, wstrb, rdata_drop, waits);
	endtask

	task automatic bus_read(input logic [BUS_W-1:0] addr, output logic [BUS_W-1:0] rdata,
			output int waits);
		bus_access(addr, '0, '0, rdata, waits);
	endtask

	// one random ram read or write, reads checked against the model.
	task automatic ram_random_access(input string name, output int waits);
		logic [BUS_W-1:0]  addr;
		logic [BUS_W-1:0]  data;
		logic [BUS_W-1:0]  ctl;
		logic [BUS_W-1:0]  rdata;
		logic [RAM_AW-1:0] idx;
		logic [STRB_W-1:0] strb;
		addr = $urandom();
		data = $urandom();
		ctl  = $urandom();
		idx  = addr[RAM_AW+1:2];
		strb = ctl[STRB_W-1:0];
		addr = {REGION_RAM, addr[27:2], 2'b00};   // offsets above the ram alias.
		if (ctl[4] && strb != '0) begin
			ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
			bus_write(addr, data, strb, waits);
		end else begin
			bus_read(addr, rdata, waits);
			check_word(name, ram_model[idx], rdata);
		end
	endtask

	// ####################################################################
	// tests
	// ####################################################################
	initial begin
		logic [BUS_W-1:0]  r_addr;
		logic [BUS_W-1:0]  r_data;
		logic [BUS_W-1:0]  r_ctl;
		logic [BUS_W-1:0]  rdata;
		logic [BUS_W-1:0]  div_model;
		logic [BUS_W-1:0]  next_div;
		logic [STRB_W-1:0] strb;
		logic [LED_W-1:0]  led_model;
		logic [RAM_AW-1:0] idx;
		logic [7:0]        tx_byte;
		int                waits;
		int                polls;
		bit                got;
		int unsigned       seed_sink;

		seed_sink = $urandom(32'hc2a0);
		resetn    = 1'b0;
		mem_valid = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		{errors, checks, err_mark, chk_mark, tests_run, tests_failed} = '0;
		repeat (3) @(posedge clk48m);
		@(negedge clk48m);
		resetn = 1'b1;

		for (int i = 0; i < RAM_WORDS; i++) begin
			idx = i[RAM_AW-1:0];
			ram_model[idx] = fill_word(idx);
			bus_write({REGION_RAM, 18'd0, idx, 2'b00}, ram_model[idx], '1, waits);
		end
		repeat (300)
			ram_random_access("ram_random", waits);
		end_test("ram_random");

		repeat (40) begin
			ram_random_access("ram_timing", waits);
			check_cycles("ram_timing", 1, waits);
		end
		end_test("ram_timing");

		check_led("led_reset", '0, led);
		led_model = '0;
		repeat (40) begin
			r_data = $urandom();
			r_ctl  = $urandom();
			strb   = r_ctl[STRB_W-1:0] | 4'b0010;   // always a write.
			if (strb[0])
				led_model = r_data[LED_W-1:0];
			bus_write(CTRL_LED, r_data, strb, waits);
			check_led("led_port", led_model, led);
			bus_read(CTRL_LED, rdata, waits);
			check_word("led_readback", {{(BUS_W-LED_W){1'b0}}, led_model}, rdata);
		end
		bus_write(CTRL_LED + 32'h4, '1, '1, waits);
		bus_read(CTRL_LED + 32'h4, rdata, waits);
		check_word("ctrl_unused", '0, rdata);
		check_led("led_port", led_model, led);
		end_test("ctrl_led");

		bus_read(UART_DIV, rdata, waits);
		check_word("div_reset", UART_DIV_RESET, rdata);
		bus_read(UART_DATA, rdata, waits);
		check_word("rx_reset", UART_EMPTY, rdata);
		div_model = UART_DIV_RESET;
		repeat (24) begin
			r_data   = $urandom();
			r_ctl    = $urandom_range(1, 15);
			strb     = r_ctl[STRB_W-1:0];
			next_div = merge_bytes(div_model, r_data, strb);
			if (next_div < 8) begin
				r_data   = r_data | 32'h08080808;   // lowest usable divider is 8.
				next_div = merge_bytes(div_model, r_data, strb);
			end
			div_model = next_div;
			bus_write(UART_DIV, r_data, strb, waits);
			bus_read(UART_DIV, rdata, waits);
			check_word("div_rw", div_model, rdata);
		end
		bus_write(UART_DIV, UART_DIV_RESET, '1, waits);
		bus_read(UART_DIV, rdata, waits);
		check_word("div_restore", UART_DIV_RESET, rdata);
		end_test("uart_divider");

		repeat (8) begin
			r_data  = $urandom();
			r_ctl   = $urandom();
			tx_byte = r_data[7:0];
			bus_write(UART_DATA, r_data, r_ctl[STRB_W-1:0] | 4'b0001, waits);
			got   = 1'b0;
			polls = 0;
			while (!got && polls < POLL_LIMIT) begin
				bus_read(UART_DATA, rdata, waits);
				got = (rdata !== UART_EMPTY);
				polls++;
			end
			if (!got) begin
				errors++;
				$display("byte %h never came back on the loopback after %0d reads",
					tx_byte, polls);
			end else begin
				check_word("loopback", {24'd0, tx_byte}, rdata);
				bus_read(UART_DATA, rdata, waits);
				check_word("rx_cleared", UART_EMPTY, rdata);
			end
		end
		end_test("uart_loopback");

		repeat (20) begin
			r_addr = $urandom();
			r_data = $urandom();
			r_ctl  = $urandom_range(3, 15);
			r_addr = {r_ctl[3:0], r_addr[27:0]};
			bus_read(r_addr, rdata, waits);
			check_word("unmapped_read", DEAD_WORD, rdata);
			check_cycles("unmapped_ready", 0, waits);
			bus_write(r_addr, r_data, '1, waits);
			check_cycles("unmapped_ready", 0, waits);
		end
		end_test("unmapped");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog/bus_decoder.sv
// bus decoder.
// splits the cpu memory port into regions by the top address nibble,
// drives one target select and muxes read data and ready back.

`timescale 1ns/10ps

module bus_decoder import soc_pkg::*; (
	input  logic                clk48m,
	input  logic                resetn,
	input  logic                mem_valid,
	input  logic [BUS_W-1:0]    mem_addr,
	input  logic [BUS_W-1:0]    mem_wdata,
	input  logic [STRB_W-1:0]   mem_wstrb,
	output logic                mem_ready,
	output logic [BUS_W-1:0]    mem_rdata,
	periph_bus_if.decoder       ram,
	periph_bus_if.decoder       uart,
	periph_bus_if.decoder       ctrl
);

	logic [3:0] region;

	assign region = mem_addr[BUS_W-1:BUS_W-4];

	// ##################################################################
	// target selects
	// ##################################################################
	assign ram.sel  = mem_valid && (region == REGION_RAM);
	assign uart.sel = mem_valid && (region == REGION_UART);
	assign ctrl.sel = mem_valid && (region == REGION_CTRL);

	// payload fans out to every target.
	assign ram.word_addr  = mem_addr[RAM_AW+1:2];
	assign uart.word_addr = mem_addr[RAM_AW+1:2];
	assign ctrl.word_addr = mem_addr[RAM_AW+1:2];

	assign ram.wdata  = mem_wdata;
	assign uart.wdata = mem_wdata;
	assign ctrl.wdata = mem_wdata;

	assign ram.wstrb  = mem_wstrb;
	assign uart.wstrb = mem_wstrb;
	assign ctrl.wstrb = mem_wstrb;

	// ##################################################################
	// return path
	// ##################################################################
	always_comb begin
		case (region)
			REGION_RAM: begin
				mem_rdata = ram.rdata;
				mem_ready = ram.ready;
			end
			REGION_UART: begin
				mem_rdata = uart.rdata;
				mem_ready = uart.ready;
			end
			REGION_CTRL: begin
				mem_rdata = ctrl.rdata;
				mem_ready = ctrl.ready;
			end
			default: begin
				// unmapped, complete at once.
				mem_rdata = DEAD_WORD;
				mem_ready = mem_valid;
			end
		endcase
	end

	// a completion only answers a live request.
	assert property (@(posedge clk48m) disable iff (!resetn)
		mem_ready |-> mem_valid);

endmodule

// File: verilog/ctrl_regs.sv
// control registers.
// led output register at offset 0 with readback.

`timescale 1ns/10ps

module ctrl_regs import soc_pkg::*; (
	input  logic              clk48m,
	input  logic              resetn,
	periph_bus_if.target      bus,
	output logic [LED_W-1:0]  led
);

	logic [LED_W-1:0] led_q;
	logic             led_hit;

	assign led_hit = (bus.word_addr == '0);

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			led_q <= '0;
		end else if (bus.sel && led_hit && bus.wstrb[0]) begin
			led_q <= bus.wdata[LED_W-1:0];
		end
	end

	// other offsets read as zero.
	assign bus.rdata = led_hit ? {{(BUS_W-LED_W){1'b0}}, led_q} : '0;
	assign bus.ready = bus.sel;

	assign led = led_q;

endmodule

// File: verilog/periph_bus_if.sv
// peripheral target port.
// one decoded slice of the memory bus between decoder and a target.

`timescale 1ns/10ps

interface periph_bus_if import soc_pkg::*; ();

	logic                sel;         // request is for this target.
	logic [RAM_AW-1:0]   word_addr;   // word offset in the region.
	logic [BUS_W-1:0]    wdata;
	logic [STRB_W-1:0]   wstrb;       // all zero means read.
	logic [BUS_W-1:0]    rdata;
	logic                ready;

	modport decoder (
		output sel,
		output word_addr,
		output wdata,
		output wstrb,
		input  rdata,
		input  ready
	);

	modport target (
		input  sel,
		input  word_addr,
		input  wdata,
		input  wstrb,
		output rdata,
		output ready
	);

endinterface

// File: verilog/simple_uart.sv
// simple uart.
// 8n1 transmitter and receiver with a programmable bit divider.
// data writes stall while sending, data reads never block.

`timescale 1ns/10ps

module simple_uart import soc_pkg::*; (
	input  logic          clk48m,
	input  logic          resetn,
	periph_bus_if.target  bus,
	output logic          uart_tx,
	input  logic          uart_rx
);

	logic             is_div;
	logic             is_write;
	logic             dat_we;
	logic             dat_re;
	logic [BUS_W-1:0] div_q;

	logic [9:0]       tx_shift;
	logic [3:0]       tx_bits;       // bits left in the frame.
	logic [BUS_W-1:0] tx_cnt;
	logic             tx_busy;

	logic             rx_meta;
	logic             rx_sync;
	logic [3:0]       rx_step;       // 0 idle, 1 start, 2..9 data, 10 stop.
	logic [BUS_W-1:0] rx_cnt;
	logic [7:0]       rx_shift;
	logic [7:0]       rx_buf;
	logic             rx_valid;
	logic [BUS_W-1:0] dat_rdata;

	// ##################################################################
	// register access
	// ##################################################################
	assign is_div   = bus.word_addr[0];
	assign is_write = |bus.wstrb;
	assign dat_we   = bus.sel && !is_div && bus.wstrb[0];
	assign dat_re   = bus.sel && !is_div && !is_write;
	assign tx_busy  = (tx_bits != 4'd0);

	assign dat_rdata = rx_valid ? {{(BUS_W-8){1'b0}}, rx_buf} : UART_EMPTY;
	assign bus.rdata = is_div ? div_q : dat_rdata;
	assign bus.ready = bus.sel && !(dat_we && tx_busy);

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			div_q <= UART_DIV_RESET;
		end else if (bus.sel && is_div) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (bus.wstrb[i]) begin
					div_q[8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	// ##################################################################
	// transmitter
	// ##################################################################
	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			tx_shift <= '1;
			tx_bits  <= 4'd0;
			tx_cnt   <= '0;
		end else if (!tx_busy) begin
			if (dat_we) begin
				tx_shift <= {1'b1, bus.wdata[7:0], 1'b0};   // stop, data, start.
				tx_bits  <= 4'd10;
				tx_cnt   <= '0;
			end
		end else if (tx_cnt + 1'b1 >= div_q) begin
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_bits  <= tx_bits - 4'd1;
			tx_cnt   <= '0;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

	assign uart_tx = tx_shift[0];

	// ##################################################################
	// receiver
	// ##################################################################
	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			rx_step  <= 4'd0;
			rx_cnt   <= '0;
			rx_valid <= 1'b0;
		end else begin
			if (dat_re) begin
				rx_valid <= 1'b0;                // read empties the buffer.
			end
			if (rx_step == 4'd0) begin
				if (!rx_sync) begin
					rx_step <= 4'd1;
					rx_cnt  <= '0;
				end
			end else if (rx_step == 4'd1) begin
				// half a bit into the start bit.
				if (rx_cnt + 1'b1 >= (div_q >> 1)) begin
					rx_cnt  <= '0;
					rx_step <= rx_sync ? 4'd0 : 4'd2;   // glitch, back to idle.
				end else begin
					rx_cnt <= rx_cnt + 1'b1;
				end
			end else if (rx_cnt + 1'b1 >= div_q) begin
				rx_cnt <= '0;
				if (rx_step == 4'd10) begin
					rx_step <= 4'd0;
					if (rx_sync) begin
						rx_buf   <= rx_shift;        // newer byte overwrites.
						rx_valid <= 1'b1;
					end
				end else begin
					rx_shift <= {rx_sync, rx_shift[7:1]};
					rx_step  <= rx_step + 4'd1;
				end
			end else begin
				rx_cnt <= rx_cnt + 1'b1;
			end
		end
	end

	// an accepted data write starts a frame on the next cycle.
	assert property (@(posedge clk48m) disable iff (!resetn)
		(dat_we && bus.ready) |-> !tx_busy ##1 (tx_busy && !uart_tx));

endmodule

// File: verilog/soc_core.sv
// soc peripheral core.
// memory mapped ram, uart and control registers behind one
// cpu style memory port.

`timescale 1ns/10ps

module soc_core import soc_pkg::*; (
	input  logic                clk48m,
	input  logic                resetn,
	input  logic                mem_valid,
	input  logic [BUS_W-1:0]    mem_addr,
	input  logic [BUS_W-1:0]    mem_wdata,
	input  logic [STRB_W-1:0]   mem_wstrb,
	output logic                mem_ready,
	output logic [BUS_W-1:0]    mem_rdata,
	output logic [LED_W-1:0]    led,
	output logic                uart_tx,
	input  logic                uart_rx
);

	periph_bus_if ram_bus ();
	periph_bus_if uart_bus ();
	periph_bus_if ctrl_bus ();

	bus_decoder u_decoder (
		.clk48m    (clk48m),
		.resetn    (resetn),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.ram       (ram_bus.decoder),
		.uart      (uart_bus.decoder),
		.ctrl      (ctrl_bus.decoder)
	);

	sram_block u_sram (
		.clk48m (clk48m),
		.resetn (resetn),
		.bus    (ram_bus.target)
	);

	simple_uart u_uart (
		.clk48m  (clk48m),
		.resetn  (resetn),
		.bus     (uart_bus.target),
		.uart_tx (uart_tx),
		.uart_rx (uart_rx)
	);

	ctrl_regs u_ctrl (
		.clk48m (clk48m),
		.resetn (resetn),
		.bus    (ctrl_bus.target),
		.led    (led)
	);

endmodule

// File: verilog/soc_pkg.sv
// soc peripheral package.
// bus widths, region map, ram size and uart defaults shared by
// the decoder and all targets.

package soc_pkg;

	// ##################################################################
	// bus
	// ##################################################################
	localparam int BUS_W  = 32;             // data and address width.
	localparam int STRB_W = BUS_W / 8;      // one strobe per byte.

	// ##################################################################
	// region map, address bits 31..28
	// ##################################################################
	localparam logic [3:0] REGION_RAM  = 4'h0;
	localparam logic [3:0] REGION_UART = 4'h1;
	localparam logic [3:0] REGION_CTRL = 4'h2;

	// filler for unmapped regions.
	localparam logic [BUS_W-1:0] DEAD_WORD = 32'hdeadbeef;

	// ##################################################################
	// targets
	// ##################################################################
	// word ram, index from address bits 9..2, higher offsets alias.
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	// clock cycles per uart bit after reset.
	localparam logic [BUS_W-1:0] UART_DIV_RESET = 32'd16;

	// data read with nothing received.
	localparam logic [BUS_W-1:0] UART_EMPTY = {BUS_W{1'b1}};

	localparam int LED_W = 6;               // led outputs.

endpackage

// File: verilog/sram_block.sv
// on-chip word ram.
// byte strobed writes, registered read, ready one cycle after select.

`timescale 1ns/10ps

module sram_block import soc_pkg::*; (
	input  logic          clk48m,
	input  logic          resetn,
	periph_bus_if.target  bus
);

	logic [BUS_W-1:0] mem [RAM_WORDS];
	logic [BUS_W-1:0] rdata_q;
	logic             ready_q;
	logic             access;

	// no new access in the cycle after a completion.
	assign access = bus.sel && !ready_q;

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	// ##################################################################
	// storage
	// ##################################################################
	always_ff @(posedge clk48m) begin
		if (access) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (bus.wstrb[i]) begin
					mem[bus.word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
		rdata_q <= mem[bus.word_addr];   // address held by master.
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

endmodule
